//--- logic/mac_pkg.sv
`default_nettype none

package mac_pkg;

    // Datapath widths
    localparam int DATA_WIDTH = 8;
    localparam int PSUM_WIDTH = 32;
    localparam int NUM_PE     = 4;
    localparam int WORD_WIDTH = NUM_PE * DATA_WIDTH;
    localparam int ADDR_WIDTH = 8;

    // Scratchpad map, lane k of the weight word is weight k
    localparam logic [ADDR_WIDTH-1:0] WEIGHT_ADDR = 8'd0;
    localparam logic [ADDR_WIDTH-1:0] BIAS_ADDR   = 8'd1;
    localparam logic [ADDR_WIDTH-1:0] IFMAP_BASE  = 8'd16;
    localparam logic [ADDR_WIDTH-1:0] RESULT_BASE = 8'd128;

    // Run limits and result queue sizing
    localparam int MAX_VEC      = 64;
    localparam int CNT_WIDTH    = $clog2(MAX_VEC + 1);
    localparam int RESULT_DEPTH = 4;
    localparam int QPTR_WIDTH   = $clog2(RESULT_DEPTH);

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_WEIGHT,
        FETCH_BIAS,
        FETCH_STREAM,
        FETCH_DONE
    } fetch_state_t;

    // Arbiter winner, highest priority first
    typedef enum logic [1:0] {
        REQ_STORE,
        REQ_FETCH,
        REQ_HOST,
        REQ_NONE
    } requester_t;

endpackage

`default_nettype wire

//--- logic/pe.sv
`default_nettype none

module pe
    import mac_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  [DATA_WIDTH-1:0] weight_i,
    input  wire  [DATA_WIDTH-1:0] ifmap_i,
    input  wire  [PSUM_WIDTH-1:0] psum_i,
    input  wire                   weight_en_i,
    input  wire                   ifmap_en_i,
    input  wire                   psum_en_i,
    output logic [DATA_WIDTH-1:0] weight_o,
    output logic [DATA_WIDTH-1:0] ifmap_o,
    output logic [PSUM_WIDTH-1:0] psum_o,
    output logic                  weight_en_o,
    output logic                  ifmap_en_o,
    output logic                  psum_en_o
);

    logic [DATA_WIDTH-1:0]   weight_q;
    logic [DATA_WIDTH-1:0]   ifmap_q;
    logic [PSUM_WIDTH-1:0]   psum_q;
    logic [2*DATA_WIDTH-1:0] product_q;

    // Enables move one stage per cycle with the operands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_en_o <= 1'b0;
            ifmap_en_o  <= 1'b0;
            psum_en_o   <= 1'b0;
        end else begin
            weight_en_o <= weight_en_i;
            ifmap_en_o  <= ifmap_en_i;
            psum_en_o   <= psum_en_i;
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if (weight_en_i) begin
            weight_q <= weight_i;
        end
        if (ifmap_en_i) begin
            ifmap_q <= ifmap_i;
        end
        if (psum_en_i) begin
            psum_q <= psum_i;
        end
    end

    // Held input byte times the weight at the port
    always_ff @(posedge clk) begin
        product_q <= ifmap_q * weight_i;
    end

    assign psum_o   = PSUM_WIDTH'(product_q) + psum_q;
    assign weight_o = weight_q;
    assign ifmap_o  = ifmap_q;

endmodule

`default_nettype wire

//--- logic/pe_chain.sv
`default_nettype none

module pe_chain
    import mac_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  [WORD_WIDTH-1:0] weight_word_i,
    input  wire                   weight_load_i,
    input  wire  [PSUM_WIDTH-1:0] bias_i,
    input  wire                   bias_load_i,
    input  wire  [WORD_WIDTH-1:0] ifmap_word_i,
    input  wire                   ifmap_valid_i,
    output logic [PSUM_WIDTH-1:0] result_o,
    output logic                  result_valid_o
);

    logic [WORD_WIDTH-1:0] weight_hold_q;
    logic [PSUM_WIDTH-1:0] bias_hold_q;
    logic                  weight_load_q;
    logic                  psum_start_q;

    logic [NUM_PE-1:0][DATA_WIDTH-1:0] lane_ifmap;

    // Element k reads index k and drives index k+1
    logic [NUM_PE:0][PSUM_WIDTH-1:0] psum;
    logic [NUM_PE:0]                 psum_en;
    logic [NUM_PE:0]                 ifmap_en;
    logic [NUM_PE:0]                 weight_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_load_q <= 1'b0;
            psum_start_q  <= 1'b0;
        end else begin
            weight_load_q <= weight_load_i;
            // Bias joins element 0 one cycle behind its input byte
            psum_start_q  <= ifmap_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (weight_load_i) begin
            weight_hold_q <= weight_word_i;
        end
        if (bias_load_i) begin
            bias_hold_q <= bias_i;
        end
    end

    assign psum[0]      = bias_hold_q;
    assign psum_en[0]   = psum_start_q;
    assign ifmap_en[0]  = ifmap_valid_i;
    assign weight_en[0] = weight_load_q;

    for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
        // Lane k is late by k cycles to meet the cascading sum
        if (k == 0) begin : g_direct
            assign lane_ifmap[k] = ifmap_word_i[k*DATA_WIDTH +: DATA_WIDTH];
        end else begin : g_skew
            logic [DATA_WIDTH-1:0] dly_q [k];

            always_ff @(posedge clk) begin
                dly_q[0] <= ifmap_word_i[k*DATA_WIDTH +: DATA_WIDTH];
                for (int s = 1; s < k; s++) begin
                    dly_q[s] <= dly_q[s-1];
                end
            end

            assign lane_ifmap[k] = dly_q[k-1];
        end

        pe u_pe (
            .clk         (clk),
            .rst_n       (rst_n),
            .weight_i    (weight_hold_q[k*DATA_WIDTH +: DATA_WIDTH]),
            .ifmap_i     (lane_ifmap[k]),
            .psum_i      (psum[k]),
            .weight_en_i (weight_en[k]),
            .ifmap_en_i  (ifmap_en[k]),
            .psum_en_i   (psum_en[k]),
            .weight_o    (),
            .ifmap_o     (),
            .psum_o      (psum[k+1]),
            .weight_en_o (weight_en[k+1]),
            .ifmap_en_o  (ifmap_en[k+1]),
            .psum_en_o   (psum_en[k+1])
        );
    end

    // NUM_PE + 1 cycles after the stream strobe
    assign result_o       = psum[NUM_PE];
    assign result_valid_o = psum_en[NUM_PE];

endmodule

`default_nettype wire

//--- logic/scratchpad.sv
`default_nettype none

module scratchpad
    import mac_pkg::*;
(
    input  wire                   clk,
    input  wire                   we_i,
    input  wire  [ADDR_WIDTH-1:0] addr_i,
    input  wire  [WORD_WIDTH-1:0] wdata_i,
    output logic [WORD_WIDTH-1:0] rdata_o
);

    logic [WORD_WIDTH-1:0] mem_q [2**ADDR_WIDTH];

    // Read returns the old word when the same address is written
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];
    end

endmodule

`default_nettype wire

//--- logic/spad_arbiter.sv
`default_nettype none

module spad_arbiter
    import mac_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   store_req_i,
    input  wire  [ADDR_WIDTH-1:0] store_addr_i,
    input  wire  [WORD_WIDTH-1:0] store_wdata_i,
    input  wire                   fetch_req_i,
    input  wire  [ADDR_WIDTH-1:0] fetch_addr_i,
    input  wire                   host_req_i,
    input  wire                   host_we_i,
    input  wire  [ADDR_WIDTH-1:0] host_addr_i,
    input  wire  [WORD_WIDTH-1:0] host_wdata_i,
    input  wire  [WORD_WIDTH-1:0] mem_rdata_i,
    output logic                  store_gnt_o,
    output logic                  fetch_gnt_o,
    output logic [WORD_WIDTH-1:0] fetch_rdata_o,
    output logic                  fetch_rvalid_o,
    output logic                  host_gnt_o,
    output logic [WORD_WIDTH-1:0] host_rdata_o,
    output logic                  host_rvalid_o,
    output logic                  mem_we_o,
    output logic [ADDR_WIDTH-1:0] mem_addr_o,
    output logic [WORD_WIDTH-1:0] mem_wdata_o
);

    requester_t winner;
    requester_t rd_owner_q;

    always_comb begin
        if (store_req_i) begin
            winner = REQ_STORE;
        end else if (fetch_req_i) begin
            winner = REQ_FETCH;
        end else if (host_req_i) begin
            winner = REQ_HOST;
        end else begin
            winner = REQ_NONE;
        end
    end

    assign store_gnt_o = (winner == REQ_STORE);
    assign fetch_gnt_o = (winner == REQ_FETCH);
    assign host_gnt_o  = (winner == REQ_HOST);

    // Memory port follows the winner
    always_comb begin
        mem_we_o    = 1'b0;
        mem_addr_o  = host_addr_i;
        mem_wdata_o = host_wdata_i;
        case (winner)
            REQ_STORE: begin
                mem_we_o    = 1'b1;
                mem_addr_o  = store_addr_i;
                mem_wdata_o = store_wdata_i;
            end
            REQ_FETCH: begin
                mem_addr_o = fetch_addr_i;
            end
            REQ_HOST: begin
                mem_we_o = host_we_i;
            end
            default: begin
                mem_we_o = 1'b0;
            end
        endcase
    end

    // Who gets next cycle's read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_owner_q <= REQ_NONE;
        end else if (winner == REQ_FETCH || (winner == REQ_HOST && !host_we_i)) begin
            rd_owner_q <= winner;
        end else begin
            rd_owner_q <= REQ_NONE;
        end
    end

    assign fetch_rvalid_o = (rd_owner_q == REQ_FETCH);
    assign host_rvalid_o  = (rd_owner_q == REQ_HOST);
    assign fetch_rdata_o  = mem_rdata_i;
    assign host_rdata_o   = mem_rdata_i;

endmodule

`default_nettype wire

//--- logic/operand_fetch.sv
`default_nettype none

module operand_fetch
    import mac_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start_i,
    input  wire  [CNT_WIDTH-1:0]  vec_count_i,
    input  wire                   gnt_i,
    input  wire  [WORD_WIDTH-1:0] rdata_i,
    input  wire                   rvalid_i,
    input  wire                   queue_room_i,
    output logic                  req_o,
    output logic [ADDR_WIDTH-1:0] addr_o,
    output logic [WORD_WIDTH-1:0] weight_word_o,
    output logic                  weight_load_o,
    output logic [PSUM_WIDTH-1:0] bias_o,
    output logic                  bias_load_o,
    output logic [WORD_WIDTH-1:0] ifmap_word_o,
    output logic                  ifmap_valid_o
);

    fetch_state_t         state_q;
    fetch_state_t         state_d;
    fetch_state_t         pend_q;
    logic [CNT_WIDTH-1:0] issued_q;
    logic                 more_vec;

    assign more_vec = (issued_q != vec_count_i);

    always_comb begin
        state_d = state_q;
        req_o   = 1'b0;
        addr_o  = WEIGHT_ADDR;
        case (state_q)
            FETCH_IDLE: begin
                if (start_i) begin
                    state_d = FETCH_WEIGHT;
                end
            end
            FETCH_WEIGHT: begin
                req_o = 1'b1;
                if (gnt_i) begin
                    state_d = FETCH_BIAS;
                end
            end
            FETCH_BIAS: begin
                req_o  = 1'b1;
                addr_o = BIAS_ADDR;
                if (gnt_i) begin
                    state_d = FETCH_STREAM;
                end
            end
            FETCH_STREAM: begin
                // Hold off new vectors when the result queue is short of room
                req_o  = more_vec && queue_room_i;
                addr_o = IFMAP_BASE + ADDR_WIDTH'(issued_q);
                if (!more_vec) begin
                    state_d = FETCH_DONE;
                end
            end
            default: begin
                state_d = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= FETCH_IDLE;
            pend_q   <= FETCH_IDLE;
            issued_q <= '0;
        end else begin
            state_q <= state_d;
            // Tag the read so its data lands on the right strobe
            if (gnt_i) begin
                pend_q <= state_q;
            end
            if (state_q == FETCH_IDLE) begin
                issued_q <= '0;
            end else if (gnt_i && state_q == FETCH_STREAM) begin
                issued_q <= issued_q + 1'b1;
            end
        end
    end

    assign weight_load_o = rvalid_i && (pend_q == FETCH_WEIGHT);
    assign bias_load_o   = rvalid_i && (pend_q == FETCH_BIAS);
    assign ifmap_valid_o = rvalid_i && (pend_q == FETCH_STREAM);
    assign weight_word_o = rdata_i;
    assign bias_o        = rdata_i;
    assign ifmap_word_o  = rdata_i;

endmodule

`default_nettype wire

//--- logic/result_store.sv
`default_nettype none

module result_store
    import mac_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start_i,
    input  wire  [CNT_WIDTH-1:0]  vec_count_i,
    input  wire  [PSUM_WIDTH-1:0] result_i,
    input  wire                   result_valid_i,
    input  wire                   gnt_i,
    output logic                  req_o,
    output logic [ADDR_WIDTH-1:0] addr_o,
    output logic [WORD_WIDTH-1:0] wdata_o,
    output logic                  queue_room_o,
    output logic                  busy_o,
    output logic                  done_o
);

    logic [PSUM_WIDTH-1:0] queue_q [RESULT_DEPTH];
    logic [QPTR_WIDTH-1:0] head_q;
    logic [QPTR_WIDTH-1:0] tail_q;
    logic [QPTR_WIDTH:0]   count_q;
    logic [CNT_WIDTH-1:0]  written_q;
    logic                  last_write;
    logic                  accept;

    assign req_o      = (count_q != '0);
    assign addr_o     = RESULT_BASE + ADDR_WIDTH'(written_q);
    assign wdata_o    = queue_q[head_q];
    assign last_write = gnt_i && ((written_q + 1'b1) == vec_count_i);
    assign accept     = start_i && !busy_o;

    // A word leaves every cycle the queue is not empty, so one
    // spare slot past the arriving result is enough
    assign queue_room_o = (count_q < RESULT_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (result_valid_i) begin
            queue_q[tail_q] <= result_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            written_q <= '0;
            busy_o    <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            if (result_valid_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (gnt_i) begin
                head_q    <= head_q + 1'b1;
                written_q <= written_q + 1'b1;
            end
            count_q <= count_q + (QPTR_WIDTH+1)'(result_valid_i)
                               - (QPTR_WIDTH+1)'(gnt_i);
            // An empty run finishes at once
            done_o  <= last_write || (accept && vec_count_i == '0);
            if (accept) begin
                written_q <= '0;
                busy_o    <= (vec_count_i != '0);
            end else if (last_write) begin
                busy_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mac_array_top.sv
`default_nettype none

module mac_array_top
    import mac_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start_i,
    input  wire  [CNT_WIDTH-1:0]  vec_count_i,
    input  wire                   host_req_i,
    input  wire                   host_we_i,
    input  wire  [ADDR_WIDTH-1:0] host_addr_i,
    input  wire  [WORD_WIDTH-1:0] host_wdata_i,
    output logic                  host_gnt_o,
    output logic [WORD_WIDTH-1:0] host_rdata_o,
    output logic                  host_rvalid_o,
    output logic                  busy_o,
    output logic                  done_o
);

    // Peer to arbiter
    logic                  store_req;
    logic                  store_gnt;
    logic [ADDR_WIDTH-1:0] store_addr;
    logic [WORD_WIDTH-1:0] store_wdata;
    logic                  fetch_req;
    logic                  fetch_gnt;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    logic [WORD_WIDTH-1:0] fetch_rdata;
    logic                  fetch_rvalid;
    logic                  queue_room;

    // Arbiter to memory
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [WORD_WIDTH-1:0] mem_wdata;
    logic [WORD_WIDTH-1:0] mem_rdata;

    // Fetcher to chain to store
    logic [WORD_WIDTH-1:0] weight_word;
    logic                  weight_load;
    logic [PSUM_WIDTH-1:0] bias;
    logic                  bias_load;
    logic [WORD_WIDTH-1:0] ifmap_word;
    logic                  ifmap_valid;
    logic [PSUM_WIDTH-1:0] result;
    logic                  result_valid;

    operand_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .vec_count_i   (vec_count_i),
        .gnt_i         (fetch_gnt),
        .rdata_i       (fetch_rdata),
        .rvalid_i      (fetch_rvalid),
        .queue_room_i  (queue_room),
        .req_o         (fetch_req),
        .addr_o        (fetch_addr),
        .weight_word_o (weight_word),
        .weight_load_o (weight_load),
        .bias_o        (bias),
        .bias_load_o   (bias_load),
        .ifmap_word_o  (ifmap_word),
        .ifmap_valid_o (ifmap_valid)
    );

    pe_chain u_chain (
        .clk            (clk),
        .rst_n          (rst_n),
        .weight_word_i  (weight_word),
        .weight_load_i  (weight_load),
        .bias_i         (bias),
        .bias_load_i    (bias_load),
        .ifmap_word_i   (ifmap_word),
        .ifmap_valid_i  (ifmap_valid),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

    result_store u_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .vec_count_i    (vec_count_i),
        .result_i       (result),
        .result_valid_i (result_valid),
        .gnt_i          (store_gnt),
        .req_o          (store_req),
        .addr_o         (store_addr),
        .wdata_o        (store_wdata),
        .queue_room_o   (queue_room),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    spad_arbiter u_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .store_req_i    (store_req),
        .store_addr_i   (store_addr),
        .store_wdata_i  (store_wdata),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .host_req_i     (host_req_i),
        .host_we_i      (host_we_i),
        .host_addr_i    (host_addr_i),
        .host_wdata_i   (host_wdata_i),
        .mem_rdata_i    (mem_rdata),
        .store_gnt_o    (store_gnt),
        .fetch_gnt_o    (fetch_gnt),
        .fetch_rdata_o  (fetch_rdata),
        .fetch_rvalid_o (fetch_rvalid),
        .host_gnt_o     (host_gnt_o),
        .host_rdata_o   (host_rdata_o),
        .host_rvalid_o  (host_rvalid_o),
        .mem_we_o       (mem_we),
        .mem_addr_o     (mem_addr),
        .mem_wdata_o    (mem_wdata)
    );

    scratchpad u_spad (
        .clk     (clk),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

//--- test/tb_mac_array.sv
`default_nettype none

module tb_mac_array
    import mac_pkg::*;
;

    localparam int HALF_PERIOD = 20;
    localparam int CLK_PERIOD  = 2 * HALF_PERIOD;
    localparam int DRIVE_DLY   = 2;
    localparam int RESET_CYCLES = 16;
    localparam int SEED        = 68925;
    localparam int GRANT_LIMIT = 1000;
    localparam int RUN_LIMIT   = 2000;

    // Rough length of every test in cycles
    localparam int HOST_OP_CYCLES  = 4;
    localparam int HOST_OPS        = 32 + 4 + 130 + 69 + 9;
    localparam int RUN_VECTORS     = 1 + MAX_VEC + MAX_VEC + 8;
    localparam int RUN_VEC_CYCLES  = 2;
    localparam int RUN_OVERHEAD    = 20;
    localparam int NUM_RUNS        = 4;
    localparam int TEST_CYCLES     = RESET_CYCLES + 5 + HOST_OPS * HOST_OP_CYCLES
                                   + RUN_VECTORS * RUN_VEC_CYCLES + NUM_RUNS * RUN_OVERHEAD;
    localparam int WATCHDOG_MARGIN = 4;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start;
    logic [CNT_WIDTH-1:0]  vec_count;
    logic                  host_req;
    logic                  host_we;
    logic [ADDR_WIDTH-1:0] host_addr;
    logic [WORD_WIDTH-1:0] host_wdata;
    wire                   host_gnt;
    wire  [WORD_WIDTH-1:0] host_rdata;
    wire                   host_rvalid;
    wire                   busy;
    wire                   done;

    // Reference copies of what the host wrote
    logic [WORD_WIDTH-1:0] weight_m;
    logic [PSUM_WIDTH-1:0] bias_m;
    logic [WORD_WIDTH-1:0] vec_m [MAX_VEC];

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;

    mac_array_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start),
        .vec_count_i   (vec_count),
        .host_req_i    (host_req),
        .host_we_i     (host_we),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .host_gnt_o    (host_gnt),
        .host_rdata_o  (host_rdata),
        .host_rvalid_o (host_rvalid),
        .busy_o        (busy),
        .done_o        (done)
    );

    always #HALF_PERIOD clk = ~clk;

    initial begin
        #(TEST_CYCLES * WATCHDOG_MARGIN * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run is stuck",
                 TEST_CYCLES * WATCHDOG_MARGIN);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic step_cycle;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Bias plus the dot product of the four byte lanes within 32 bits
    function automatic logic [PSUM_WIDTH-1:0] expected_sum(input logic [WORD_WIDTH-1:0] w,
                                                           input logic [PSUM_WIDTH-1:0] b,
                                                           input logic [WORD_WIDTH-1:0] x);
        logic [PSUM_WIDTH-1:0] acc;
        int                    k;
        acc = b;
        for (k = 0; k < NUM_PE; k++) begin
            acc = acc + PSUM_WIDTH'(w[k*DATA_WIDTH +: DATA_WIDTH])
                      * PSUM_WIDTH'(x[k*DATA_WIDTH +: DATA_WIDTH]);
        end
        return acc;
    endfunction

    // Grant is sampled mid-cycle and the access lands on the next rising edge
    task automatic wait_host_grant(output bit granted);
        int waited;
        waited  = 0;
        granted = 1'b0;
        while (!granted && waited < GRANT_LIMIT) begin
            @(negedge clk);
            if (host_gnt) begin
                granted = 1'b1;
            end else begin
                waited++;
            end
        end
    endtask

    task automatic host_write(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [WORD_WIDTH-1:0] data);
        bit granted;
        host_req   = 1'b1;
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        wait_host_grant(granted);
        step_cycle();
        host_req = 1'b0;
        host_we  = 1'b0;
        if (!granted) begin
            $display("Host write to address %0d was never granted", addr);
            error_count++;
        end
    endtask

    task automatic host_read(input logic [ADDR_WIDTH-1:0] addr,
                             output logic [WORD_WIDTH-1:0] data);
        bit granted;
        data      = '0;
        host_req  = 1'b1;
        host_we   = 1'b0;
        host_addr = addr;
        wait_host_grant(granted);
        if (granted) begin
            check_value("host_rvalid_o", 32'd0, 32'(host_rvalid));
        end
        step_cycle();
        host_req = 1'b0;
        if (granted) begin
            @(negedge clk);
            check_value("host_rvalid_o", 32'd1, 32'(host_rvalid));
            data = host_rdata;
            step_cycle();
        end else begin
            $display("Host read of address %0d was never granted", addr);
            error_count++;
        end
    endtask

    task automatic load_operands(input int n);
        int j;
        host_write(WEIGHT_ADDR, weight_m);
        host_write(BIAS_ADDR, bias_m);
        for (j = 0; j < n; j++) begin
            host_write(IFMAP_BASE + ADDR_WIDTH'(j), vec_m[j]);
        end
    endtask

    // Busy stays high up to done and done lasts one cycle
    task automatic run_vectors(input int n);
        bit done_seen;
        int waited;
        start     = 1'b1;
        vec_count = CNT_WIDTH'(n);
        step_cycle();
        start     = 1'b0;
        done_seen = 1'b0;
        waited    = 0;
        while (!done_seen && waited < RUN_LIMIT) begin
            @(negedge clk);
            if (done) begin
                done_seen = 1'b1;
                check_value("busy_o", 32'd0, 32'(busy));
            end else begin
                check_value("busy_o", 32'd1, 32'(busy));
                waited++;
            end
        end
        if (done_seen) begin
            @(negedge clk);
            check_value("done_o", 32'd0, 32'(done));
            check_value("busy_o", 32'd0, 32'(busy));
        end else begin
            $display("Run of %0d vectors never signalled done", n);
            error_count++;
        end
        step_cycle();
    endtask

    task automatic check_results(input int n);
        logic [WORD_WIDTH-1:0] data;
        string                 name;
        int                    j;
        for (j = 0; j < n; j++) begin
            host_read(RESULT_BASE + ADDR_WIDTH'(j), data);
            name = $sformatf("host_rdata_o result %0d", j);
            check_value(name, expected_sum(weight_m, bias_m, vec_m[j]), data);
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("Test %0d %s finished, %0d errors so far", test_count, name, error_count);
    endtask

    initial begin
        logic [WORD_WIDTH-1:0] words [16];
        logic [WORD_WIDTH-1:0] data;
        int                    i;

        rst_n      = 1'b0;
        start      = 1'b0;
        vec_count  = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // Quiet outputs until someone asks
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value("busy_o", 32'd0, 32'(busy));
            check_value("done_o", 32'd0, 32'(done));
            check_value("host_gnt_o", 32'd0, 32'(host_gnt));
            check_value("host_rvalid_o", 32'd0, 32'(host_rvalid));
        end
        step_cycle();
        report_test("reset state");

        // Spare region above the results
        for (i = 0; i < 16; i++) begin
            words[i] = $urandom();
            host_write(ADDR_WIDTH'(200 + i), words[i]);
        end
        for (i = 0; i < 16; i++) begin
            host_read(ADDR_WIDTH'(200 + i), data);
            check_value("host_rdata_o", words[i], data);
        end
        report_test("memory round trip");

        weight_m = $urandom();
        bias_m   = $urandom() & 32'h00ff_ffff;
        vec_m[0] = $urandom();
        load_operands(1);
        run_vectors(1);
        check_results(1);
        report_test("single vector");

        weight_m = {8'hff, 24'($urandom())};
        bias_m   = 32'hffff_f000;
        for (i = 0; i < MAX_VEC; i++) begin
            vec_m[i] = $urandom();
        end
        vec_m[0]           = 32'hffff_ffff;
        vec_m[MAX_VEC / 2] = 32'hffff_ffff;
        vec_m[MAX_VEC - 1] = 32'hffff_ffff;
        load_operands(MAX_VEC);
        run_vectors(MAX_VEC);
        check_results(MAX_VEC);
        report_test("full run");

        // New bias so the rerun writes different words
        bias_m = $urandom();
        host_write(BIAS_ADDR, bias_m);
        fork
            run_vectors(MAX_VEC);
            begin
                repeat (3) step_cycle();
                for (i = 0; i < 4; i++) begin
                    host_read(WEIGHT_ADDR, data);
                    check_value("host_rdata_o weight", weight_m, data);
                end
            end
        join
        check_results(MAX_VEC);
        report_test("host reads during run");

        weight_m = ~weight_m ^ 32'h0101_0101;
        host_write(WEIGHT_ADDR, weight_m);
        run_vectors(8);
        check_results(8);
        report_test("new weights");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/mac_pkg.sv
logic/pe.sv
logic/pe_chain.sv
logic/scratchpad.sv
logic/spad_arbiter.sv
logic/operand_fetch.sv
logic/result_store.sv
logic/mac_array_top.sv
test/tb_mac_array.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -f sim.f --top-module tb_mac_array \
    -o tb_mac_array > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

./obj_dir/tb_mac_array > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -qx "NO ERRORS" "$SIM_LOG" && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
